// File: sources.f
uartPkg.sv
uartBaudGen.sv
uartRec.sv
uartRxFifo.sv
uartRxPort.sv
uartRxSubsystem.sv
uartRxChecker.sv
tbUartRx.sv

// File: tbUartRx.sv
// testbench top: clock, reset, serial frame driver, read requests and test sequence
`timescale 1ns/1ns

module tbUartRx;

	import uartPkg::*;

	localparam int clksPerTick = 4;
	localparam int sbTick      = 16;
	localparam int fifoDepth   = 8;
	localparam int clksPerBit  = 16 * clksPerTick; // 64 clocks on the line per bit
	localparam int readTimeout = 20;
	localparam logic dataReq   = 1'b0;
	localparam logic statusReq = 1'b1;

	logic clk, reset, rx, rdData, rdStat, readValid;
	rxReadWord readWord;
	logic frameValid;                   // tells the checker a frame completed
	logic [dataBits-1:0] frameByte;
	int errorCount, checkCount, timeoutCount, testCount, errStart;
	integer seed;

	uartRxSubsystem #(.clksPerTick(clksPerTick), .sbTick(sbTick), .fifoDepth(fifoDepth)) DUT
	(
		.clk(clk), .reset(reset), .rx(rx), .rdData(rdData), .rdStat(rdStat),
		.readValid(readValid), .readWord(readWord)
	);

	uartRxChecker #(.fifoDepth(fifoDepth)) chk
	(
		.clk(clk), .reset(reset), .rdData(rdData), .rdStat(rdStat),
		.readValid(readValid), .readWord(readWord), .frameValid(frameValid),
		.frameByte(frameByte), .errorCount(errorCount), .checkCount(checkCount)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// line and bus drivers, all on the falling edge
	//////////////////////////////////////////////////////////////////////

	// start, 8 bits LSB first, stop; watches for the frame to land
	task automatic sendFrame(input logic [dataBits-1:0] value);
		logic landed;
		landed = 1'b0;
		rx = 1'b0;
		repeat (clksPerBit) @(negedge clk);
		for (int i = 0; i < dataBits; i++)
		begin
			rx = value[i];
			repeat (clksPerBit) @(negedge clk);
		end
		rx = 1'b1;                      // stop bit, then idle
		for (int c = 0; c < clksPerBit; c++)
		begin
			@(negedge clk);
			frameValid = 1'b0;
			if (!landed && (DUT.pushValid || DUT.overrunPulse))
			begin
				landed     = 1'b1;
				frameValid = 1'b1;
				frameByte  = value;
			end
		end
		@(negedge clk);
		frameValid = 1'b0;
		if (!landed)
		begin
			timeoutCount++;
			$display("frame %h never landed, gave up at %0t", value, $time);
		end
	endtask

	// one cycle request, then wait for the answer
	task automatic issueRead(input logic isStat);
		int w;
		if (isStat)
			rdStat = 1'b1;
		else
			rdData = 1'b1;
		@(negedge clk);
		rdStat = 1'b0;
		rdData = 1'b0;
		w = 0;
		while (!readValid && w < readTimeout)
		begin
			@(negedge clk);
			w++;
		end
		if (!readValid)
		begin
			timeoutCount++;
			$display("readValid never came for a request at %0t", $time);
		end
		@(negedge clk);
	endtask

	task automatic endTest(input string name);
		int errs;
		testCount++;
		errs = errorCount + timeoutCount - errStart;
		if (errs == 0)
			$display("test %0d %s: ok", testCount, name);
		else
			$display("test %0d %s: %0d errors", testCount, name, errs);
		errStart = errorCount + timeoutCount;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed = 32'h346b0fc7;
		clk = 1'b0;
		reset = 1'b1;
		rx = 1'b1;                      // line idles high
		rdData = 1'b0;
		rdStat = 1'b0;
		frameValid = 1'b0;
		frameByte = '0;
		timeoutCount = 0;
		testCount = 0;
		errStart = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		issueRead(statusReq);
		endTest("status after reset");

		sendFrame(8'($random(seed)));
		issueRead(dataReq);
		issueRead(statusReq);           // should be empty again
		endTest("single frame");

		for (int i = 0; i < 5; i++)
			sendFrame(8'($random(seed)));
		for (int i = 0; i < 5; i++)
			issueRead(dataReq);
		issueRead(statusReq);
		endTest("random frames in order");

		for (int i = 0; i < fifoDepth + 1; i++)
			sendFrame(8'($random(seed))); // last one has no credit
		issueRead(statusReq);
		issueRead(statusReq);           // overrun cleared by the first
		for (int i = 0; i < fifoDepth + 1; i++)
			issueRead(dataReq);
		issueRead(statusReq);
		endTest("overrun on full fifo");

		issueRead(dataReq);
		issueRead(statusReq);
		endTest("data read on empty fifo");

		// steady reads free credits faster than frames arrive
		fork
			for (int k = 0; k < 12; k++)
				sendFrame(8'($random(seed)));
			for (int j = 0; j < 30; j++)
			begin
				issueRead(dataReq);
				repeat (250) @(negedge clk);
			end
		join
		for (int i = 0; i < 3; i++)
			issueRead(dataReq);         // drain what is left
		issueRead(statusReq);
		endTest("interleaved stream");

		$display("tests %0d, checks %0d, errors %0d, timeouts %0d",
			testCount, checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0 && checkCount > 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: uartRxChecker.sv
// testbench checker with fifo model, reference read word and response compare
`timescale 1ns/1ns

module uartRxChecker
#(
	parameter int fifoDepth = 8         // must match the dut
)
(
	input  logic clk,
	input  logic reset,
	input  logic rdData,
	input  logic rdStat,
	input  logic readValid,
	input  uartPkg::rxReadWord readWord,
	input  logic frameValid,            // a sent frame just completed on the line
	input  logic [uartPkg::dataBits-1:0] frameByte,
	output int errorCount,
	output int checkCount
);

	import uartPkg::*;

	logic [dataBits-1:0] model [$];     // bytes held by the fifo, oldest first
	logic ovrModel;                     // sticky overrun as the port should keep it
	rxReadWord expWord [$];             // answers still owed by the dut
	logic expIsStat [$];
	logic [dataBits-1:0] headByte;
	rxReadWord expNow;
	logic statNow;
	logic reqLast;                      // request sampled on the previous edge

	initial
	begin
		errorCount = 0;
		checkCount = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// reference answer for one request
	//////////////////////////////////////////////////////////////////////

	function automatic rxReadWord refWord(input logic isStat, input int count,
		input logic [dataBits-1:0] head, input logic ovr);
		rxReadWord w;
		w = '0;                         // empty data read reads as 0
		if (isStat)
		begin
			w.status.overrun = ovr;
			w.status.full    = (count == fifoDepth);
			w.status.empty   = (count == 0);
			w.status.count   = $bits(w.status.count)'(count);
		end
		else if (count != 0)
			w.byteData = head;          // oldest byte comes out first
		return w;
	endfunction

	// requests are served before the frame of the same edge lands
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			model.delete();
			ovrModel = 1'b0;
		end
		else
		begin
			if (rdData || rdStat)
			begin
				headByte = (model.size() != 0) ? model[0] : '0;
				expWord.push_back(refWord(rdStat, model.size(), headByte, ovrModel));
				expIsStat.push_back(rdStat);
				if (rdStat)
					ovrModel = 1'b0;    // status read clears it
				else if (model.size() != 0)
					void'(model.pop_front());
			end
			if (frameValid)
			begin
				if (model.size() < fifoDepth)
					model.push_back(frameByte);
				else
					ovrModel = 1'b1;    // no room, byte lost
			end
		end
	end

	// readValid follows each request by exactly one edge
	always @(posedge clk or posedge reset)
	begin
		if (reset)
			reqLast = 1'b0;
		else
		begin
			if (readValid !== reqLast)
			begin
				errorCount++;
				$display("readValid at %0t did not come exactly one cycle after its request",
					$time);
			end
			reqLast = rdData || rdStat;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare every answer, decoded through the member it was built as
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (!reset && readValid)
		begin
			if (expWord.size() == 0)
			begin
				errorCount++;
				$display("readValid came at %0t with no request pending", $time);
			end
			else
			begin
				expNow  = expWord.pop_front();
				statNow = expIsStat.pop_front();
				checkCount++;
				if (statNow && readWord.status !== expNow.status)
				begin
					errorCount++;
					$display("mismatch at %0t: status %b/%b/%b/%0d, expected %b/%b/%b/%0d",
						$time, readWord.status.overrun, readWord.status.full,
						readWord.status.empty, readWord.status.count,
						expNow.status.overrun, expNow.status.full,
						expNow.status.empty, expNow.status.count);
				end
				else if (!statNow && readWord.byteData !== expNow.byteData)
				begin
					errorCount++;
					$display("mismatch at %0t: data read got %h, expected %h",
						$time, readWord.byteData, expNow.byteData);
				end
			end
		end
	end

endmodule

// File: uartRxSubsystem.sv
// uart receive subsystem top: tick generator, receiver, fifo and read port
`timescale 1ns/1ns

module uartRxSubsystem
#(
	parameter int clksPerTick = 4,
	parameter int sbTick      = uartPkg::defaultSbTick,
	parameter int fifoDepth   = 8   // at most uartPkg::maxFifoDepth
)
(
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  logic rdData,
	input  logic rdStat,
	output logic readValid,
	output uartPkg::rxReadWord readWord
);

	import uartPkg::*;

	logic sTick;
	logic pushValid, creditReturn, overrunPulse, pop;
	logic [dataBits-1:0] pushData, popData;
	logic [$clog2(maxFifoDepth + 1)-1:0] fifoCount;

	//////////////////////////////////////////////////////////////////////
	// producer, buffer, consumer
	//////////////////////////////////////////////////////////////////////

	uartBaudGen #(.clksPerTick(clksPerTick)) baudGen
	(
		.clk(clk), .reset(reset), .sTick(sTick)
	);

	uartRec #(.sbTick(sbTick), .fifoDepth(fifoDepth)) rec
	(
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.creditReturn(creditReturn), .pushValid(pushValid),
		.pushData(pushData), .overrunPulse(overrunPulse)
	);

	uartRxFifo #(.fifoDepth(fifoDepth)) rxFifo
	(
		.clk(clk), .reset(reset), .pushValid(pushValid), .pushData(pushData),
		.pop(pop), .popData(popData), .fifoCount(fifoCount),
		.creditReturn(creditReturn)
	);

	uartRxPort #(.fifoDepth(fifoDepth)) rxPort
	(
		.clk(clk), .reset(reset), .rdData(rdData), .rdStat(rdStat),
		.fifoCount(fifoCount), .popData(popData), .overrunPulse(overrunPulse),
		.pop(pop), .readValid(readValid), .readWord(readWord)
	);

endmodule

// File: uartRxPort.sv
// processor read port: data pops, status word and sticky overrun flag
`timescale 1ns/1ns

module uartRxPort
#(
	parameter int fifoDepth = 8         // for the full flag
)
(
	input  logic clk,
	input  logic reset,
	input  logic rdData,                // one cycle request, pop head byte
	input  logic rdStat,                // one cycle request, status word
	input  logic [$clog2(uartPkg::maxFifoDepth + 1)-1:0] fifoCount,
	input  logic [uartPkg::dataBits-1:0] popData,
	input  logic overrunPulse,
	output logic pop,
	output logic readValid,
	output uartPkg::rxReadWord readWord
);

	import uartPkg::*;

	logic overrunFlag;                  // sticky until a status read
	rxStatus curStat;
	rxReadWord nextWord;

	// never pop an empty fifo, the fifo itself doesn't check
	assign pop = rdData && (fifoCount != '0);

	// status as of this cycle
	always_comb
	begin
		curStat.overrun = overrunFlag;
		curStat.full    = (fifoCount == $bits(fifoCount)'(fifoDepth));
		curStat.empty   = (fifoCount == '0);
		curStat.count   = fifoCount;
	end

	//////////////////////////////////////////////////////////////////////
	// answer word, one member filled per request
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextWord = '0;                  // empty data read answers 0
		if (rdStat)
			nextWord.status = curStat;
		else if (pop)
			nextWord.byteData = popData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			readValid   <= 1'b0;
			overrunFlag <= 1'b0;
		end
		else
		begin
			readValid <= rdData || rdStat; // answer exactly one cycle later
			if (overrunPulse)
				overrunFlag <= 1'b1;       // wins over a clearing read
			else if (rdStat)
				overrunFlag <= 1'b0;
		end
	end

	// payload only, qualified by readValid
	always_ff @(posedge clk)
	begin
		if (rdData || rdStat)
			readWord <= nextWord;
	end

endmodule

// File: uartRxFifo.sv
// receive fifo with occupancy count and registered credit return
`timescale 1ns/1ns

module uartRxFifo
#(
	parameter int fifoDepth = 8
)
(
	input  logic clk,
	input  logic reset,
	input  logic pushValid,             // always has space, credit guarantees it
	input  logic [uartPkg::dataBits-1:0] pushData,
	input  logic pop,                   // only when fifoCount nonzero
	output logic [uartPkg::dataBits-1:0] popData,
	output logic [$clog2(uartPkg::maxFifoDepth + 1)-1:0] fifoCount,
	output logic creditReturn
);

	import uartPkg::*;

	localparam int ptrBits = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

	logic [dataBits-1:0] mem [fifoDepth]; // storage, no reset
	logic [ptrBits-1:0] wrPtr, rdPtr;

	// head entry, read combinationally
	assign popData = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (pushValid)
			mem[wrPtr] <= pushData;
	end

	// pointers wrap at fifoDepth, which need not be a power of two
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			fifoCount    <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (pushValid)
				wrPtr <= (wrPtr == ptrBits'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrBits'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({pushValid, pop})
				2'b10:   fifoCount <= fifoCount + 1'b1;
				2'b01:   fifoCount <= fifoCount - 1'b1;
				default: fifoCount <= fifoCount;
			endcase
			creditReturn <= pop;        // one credit back per pop, a cycle later
		end
	end

endmodule

// File: uartRec.sv
// uart receiver fsm with credit counter toward the receive fifo
`timescale 1ns/1ns

module uartRec
#(
	parameter int sbTick    = 16,       // ticks spent in the stop bit(s)
	parameter int fifoDepth = 8         // credits available after reset
)
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,                 // 16x oversampling tick
	input  logic rx,                    // serial line, idle high
	input  logic creditReturn,          // one fifo entry freed
	output logic pushValid,
	output logic [uartPkg::dataBits-1:0] pushData,
	output logic overrunPulse           // frame done but no credit
);

	import uartPkg::*;

	//////////////////////////////////////////////////////////////////////
	// state encoding and counter widths
	//////////////////////////////////////////////////////////////////////

	localparam logic [1:0] idle = 2'b00, start = 2'b01, data = 2'b10, stop = 2'b11;

	localparam int sBits  = $clog2((sbTick > 16) ? sbTick : 16);
	localparam int nBits  = $clog2(dataBits);
	localparam int crBits = $clog2(fifoDepth + 1);

	logic [1:0] stateReg, stateNext;
	logic [sBits-1:0] sReg, sNext;      // tick counter within a bit
	logic [nBits-1:0] nReg, nNext;      // data bit index
	logic [dataBits-1:0] bReg, bNext;   // shift register, LSB first
	logic [crBits-1:0] creditReg;       // free fifo entries as seen here
	logic frameDone;                    // last stop tick seen
	logic haveCredit;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
		end
	end

	// next state
	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		frameDone = 1'b0;
		case (stateReg)
			idle:
				if (!rx)                // falling edge of start bit
				begin
					stateNext = start;
					sNext     = '0;
				end
			start:
				if (sTick)
				begin
					if (sReg == sBits'(7)) // middle of start bit
					begin
						stateNext = data;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			data:
				if (sTick)
				begin
					if (sReg == sBits'(15)) // middle of a data bit
					begin
						sNext = '0;
						bNext = {rx, bReg[dataBits-1:1]};
						if (nReg == nBits'(dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stop:
				if (sTick)
				begin
					if (sReg == sBits'(sbTick - 1))
					begin
						stateNext = idle;
						frameDone = 1'b1; // same cycle as the final tick
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = idle;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// credits, one per free fifo entry
	//////////////////////////////////////////////////////////////////////

	assign haveCredit   = (creditReg != '0);
	assign pushValid    = frameDone && haveCredit;
	assign overrunPulse = frameDone && !haveCredit; // byte lost, line can't stall
	assign pushData     = bReg;                     // complete after last data bit

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			creditReg <= crBits'(fifoDepth);
		else
			case ({pushValid, creditReturn})
				2'b10:   creditReg <= creditReg - 1'b1; // spent on push
				2'b01:   creditReg <= creditReg + 1'b1; // returned by a pop
				default: creditReg <= creditReg;        // both or neither
			endcase
	end

endmodule

// File: uartBaudGen.sv
// oversampling tick generator for the uart receiver
`timescale 1ns/1ns

module uartBaudGen
#(
	parameter int clksPerTick = 4       // clk cycles per oversampling tick
)
(
	input  logic clk,
	input  logic reset,
	output logic sTick                  // one clk wide, every clksPerTick
);

	// counter must hold at least one bit even for a divide by 1
	localparam int cntBits = (clksPerTick > 1) ? $clog2(clksPerTick) : 1;

	logic [cntBits-1:0] divCnt;         // free running modulo counter
	logic wrap;

	assign wrap = (divCnt == cntBits'(clksPerTick - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick  <= 1'b0;
		end
		else
		begin
			divCnt <= wrap ? '0 : divCnt + 1'b1;
			sTick  <= wrap;             // registered pulse, one per period
		end
	end

endmodule

// File: uartPkg.sv
// uart receive constants, status word layout and processor read word union
package uartPkg;

	//////////////////////////////////////////////////////////////////////
	// frame and buffer constants
	//////////////////////////////////////////////////////////////////////

	localparam int dataBits      = 8;   // bits per frame, LSB first
	localparam int readWordBits  = 8;   // width of a processor read
	localparam int maxFifoDepth  = 16;  // largest depth count can show
	localparam int defaultSbTick = 16;  // one stop bit at 16x oversampling

	//////////////////////////////////////////////////////////////////////
	// status view of a read word
	//////////////////////////////////////////////////////////////////////

	typedef struct packed
	{
		logic overrun;                  // byte dropped since last status read
		logic full;                     // no free entry left
		logic empty;                    // nothing to read
		logic [readWordBits-4:0] count; // fifo occupancy, 0..maxFifoDepth
	} rxStatus;

	// one read word, decoded as data or as status
	// depending on which request produced it
	typedef union packed
	{
		logic [dataBits-1:0] byteData;  // rdData answer
		rxStatus status;                // rdStat answer
	} rxReadWord;

endpackage
